// File: Bender.yml
package:
  name: xphy_rx

sources:
  # Receive housekeeping RTL
  - files:
      - source/xphy_rx_pkg.sv
      - source/rx_gearbox_map.sv
      - source/rx_cable_monitor.sv
      - source/rx_reset_sequencer.sv
      - source/xphy_rx_top.sv

  # Testbench with bound assertions
  - target: test
    files:
      - testbench/xphy_rx_assert.sv
      - testbench/xphy_rx_tb.sv

// File: source/rx_cable_monitor.sv
// Cable pull and re-plug watchdogs that request a GT RX reset and gate signal detect
`timescale 1ns/1ps

module rx_cable_monitor
(
   input  logic                                gt0_rxusrclk2_i,
   input  logic                                rst_i,
   input  logic [xphy_rx_pkg::NIBBLE_W-1:0]    rx_nibble_i,
   input  logic                                rx_resetdone_i,
   input  logic                                signal_detect_i,
   input  logic                                rxreset_ack_i,
   output logic                                rxreset_req_o,
   output logic                                cable_pulled_o,
   output logic                                signal_detect_o
);

   logic [xphy_rx_pkg::NIBBLE_W-1:0] nibble_prev_q;
   logic                             sample_good;
   logic                             frozen;
   logic                             watch_en;
   logic                             pulled_q;
   logic                             req_q;

   xphy_rx_pkg::pull_cnt_t pull_wdog_q;
   xphy_rx_pkg::run_cnt_t  good_run_q;
   xphy_rx_pkg::win_cnt_t  unpull_win_q;
   xphy_rx_pkg::evt_cnt_t  unpull_evt_q;

   // ----------------------------------------
   // Sample classification
   // ----------------------------------------
   // A live link toggles the nibble, a pulled cable shows a fixed or idle-like value
   assign sample_good = (rx_nibble_i != xphy_rx_pkg::IDLE_PAT_A) &&
                        (rx_nibble_i != xphy_rx_pkg::IDLE_PAT_B) &&
                        (rx_nibble_i != xphy_rx_pkg::IDLE_PAT_Z) &&
                        (rx_nibble_i != nibble_prev_q);

   // Watchdogs hold still during the whole req/ack exchange
   assign frozen   = req_q | rxreset_ack_i;
   assign watch_en = !frozen && rx_resetdone_i;

   always_ff @(posedge gt0_rxusrclk2_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         nibble_prev_q <= '0;
      end
      else
      begin
         nibble_prev_q <= rx_nibble_i;
      end
   end

   // ----------------------------------------
   // Pull and re-plug watchdogs
   // ----------------------------------------
   always_ff @(posedge gt0_rxusrclk2_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         pulled_q     <= 1'b0;
         req_q        <= 1'b0;
         pull_wdog_q  <= xphy_rx_pkg::pull_cnt_t'(xphy_rx_pkg::PULL_WINDOW);
         good_run_q   <= '0;
         unpull_win_q <= xphy_rx_pkg::win_cnt_t'(xphy_rx_pkg::UNPULL_WINDOW - 1);
         unpull_evt_q <= '0;
      end
      else
      begin
         // Drop the request once the sequencer has answered
         if (req_q && rxreset_ack_i)
         begin
            req_q <= 1'b0;
         end

         if (watch_en && !pulled_q)
         begin
            // Attached: expire without proof of a live cable
            if (pull_wdog_q == '0)
            begin
               req_q        <= 1'b1;
               pulled_q     <= 1'b1;
               pull_wdog_q  <= xphy_rx_pkg::pull_cnt_t'(xphy_rx_pkg::PULL_WINDOW);
               good_run_q   <= '0;
               unpull_win_q <= xphy_rx_pkg::win_cnt_t'(xphy_rx_pkg::UNPULL_WINDOW - 1);
               unpull_evt_q <= '0;
            end
            else if (sample_good &&
                     good_run_q == xphy_rx_pkg::run_cnt_t'(xphy_rx_pkg::PULL_GOOD_RUN - 1))
            begin
               pull_wdog_q <= xphy_rx_pkg::pull_cnt_t'(xphy_rx_pkg::PULL_WINDOW);
               good_run_q  <= '0;
            end
            else
            begin
               pull_wdog_q <= pull_wdog_q - 1'b1;
               // Only consecutive good samples count
               if (sample_good)
               begin
                  good_run_q <= good_run_q + 1'b1;
               end
               else
               begin
                  good_run_q <= '0;
               end
            end
         end
         else if (watch_en && pulled_q)
         begin
            // Pulled: enough good samples inside one window mean the cable is back
            if (unpull_evt_q == xphy_rx_pkg::evt_cnt_t'(xphy_rx_pkg::UNPULL_EVENTS))
            begin
               req_q        <= 1'b1;
               pulled_q     <= 1'b0;
               unpull_win_q <= xphy_rx_pkg::win_cnt_t'(xphy_rx_pkg::UNPULL_WINDOW - 1);
               unpull_evt_q <= '0;
               pull_wdog_q  <= xphy_rx_pkg::pull_cnt_t'(xphy_rx_pkg::PULL_WINDOW);
               good_run_q   <= '0;
            end
            else if (unpull_win_q == '0)
            begin
               // Window over, start counting again
               unpull_win_q <= xphy_rx_pkg::win_cnt_t'(xphy_rx_pkg::UNPULL_WINDOW - 1);
               unpull_evt_q <= '0;
            end
            else
            begin
               unpull_win_q <= unpull_win_q - 1'b1;
               if (sample_good)
               begin
                  unpull_evt_q <= unpull_evt_q + 1'b1;
               end
            end
         end
      end
   end

   assign rxreset_req_o   = req_q;
   assign cable_pulled_o  = pulled_q;

   // PCS sees no signal while the cable is considered pulled
   assign signal_detect_o = signal_detect_i & ~pulled_q;

endmodule

// File: source/rx_gearbox_map.sv
// Receive mapping from transceiver bit order to PCS order with packed control byte
`timescale 1ns/1ps

module rx_gearbox_map
(
   input  logic                                  gt0_rxusrclk2_i,
   input  logic                                  rst_i,
   input  logic [xphy_rx_pkg::GT_DATA_W-1:0]     gt_rxdata_i,
   input  logic [xphy_rx_pkg::HDR_W-1:0]         gt_rxheader_i,
   input  logic                                  gt_rxheadervalid_i,
   input  logic                                  gt_rxdatavalid_i,
   output logic [xphy_rx_pkg::GT_DATA_W-1:0]     pcs_rxd_o,
   output logic [xphy_rx_pkg::RXC_W-1:0]         pcs_rxc_o,
   output logic [xphy_rx_pkg::NIBBLE_W-1:0]      rx_nibble_o
);

   logic [xphy_rx_pkg::GT_DATA_W-1:0] rxd_rev;
   logic [xphy_rx_pkg::RXC_W-1:0]     rxc_packed;
   logic [xphy_rx_pkg::GT_DATA_W-1:0] rxd_q;
   logic [xphy_rx_pkg::RXC_W-1:0]     rxc_q;

   // Transceiver sends MSB first, PCS expects bit 0 first
   always_comb
   begin
      for (int i = 0; i < xphy_rx_pkg::GT_DATA_W; i++)
      begin
         rxd_rev[i] = gt_rxdata_i[xphy_rx_pkg::GT_DATA_W - 1 - i];
      end
   end

   // Upper bits unused, header bits swapped into PCS order
   assign rxc_packed = {{(xphy_rx_pkg::RXC_W - 4){1'b0}},
                        gt_rxheadervalid_i,
                        gt_rxdatavalid_i,
                        gt_rxheader_i[0],
                        gt_rxheader_i[1]};

   // ----------------------------------------
   // Single register stage toward the PCS
   // ----------------------------------------
   always_ff @(posedge gt0_rxusrclk2_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         rxd_q <= '0;
         rxc_q <= '0;
      end
      else
      begin
         rxd_q <= rxd_rev;
         rxc_q <= rxc_packed;
      end
   end

   assign pcs_rxd_o   = rxd_q;
   assign pcs_rxc_o   = rxc_q;

   // Nibble watched by the cable monitor
   assign rx_nibble_o = rxd_q[xphy_rx_pkg::SAMPLE_LO +: xphy_rx_pkg::NIBBLE_W];

endmodule

// File: source/rx_reset_sequencer.sv
// GT RX reset sequencing with lock handling, RXUSERRDY delay and elastic-buffer reset
`timescale 1ns/1ps

module rx_reset_sequencer
(
   input  logic                                  gt0_rxusrclk2_i,
   input  logic                                  rst_i,
   input  logic                                  qplllock_i,
   input  logic                                  gt_rxresetdone_i,
   input  logic [xphy_rx_pkg::BUFSTATUS_W-1:0]   gt_rxbufstatus_i,
   input  logic                                  rxreset_req_i,
   output logic                                  rxreset_ack_o,
   output logic                                  rx_resetdone_o,
   output logic                                  gtrxreset_o,
   output logic                                  rxuserrdy_o,
   output logic                                  rxbufreset_o
);

   logic [xphy_rx_pkg::SYNC_STAGES-1:0] lock_sync_q;
   logic [xphy_rx_pkg::SYNC_STAGES-1:0] done_sync_q;
   logic                                lock_s;
   logic                                done_s;
   logic                                req_start;
   logic                                gtrxreset_d;
   logic                                gtrxreset_q;
   logic                                ack_q;
   logic                                rxuserrdy_q;
   logic                                rxbufreset_q;

   xphy_rx_pkg::pulse_cnt_t pulse_cnt_q;
   xphy_rx_pkg::wait_cnt_t  wait_cnt_q;

   // ----------------------------------------
   // Synchronizers for lock and reset-done
   // ----------------------------------------
   always_ff @(posedge gt0_rxusrclk2_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         lock_sync_q <= '0;
         done_sync_q <= '0;
      end
      else
      begin
         lock_sync_q <= {lock_sync_q[xphy_rx_pkg::SYNC_STAGES-2:0], qplllock_i};
         done_sync_q <= {done_sync_q[xphy_rx_pkg::SYNC_STAGES-2:0], gt_rxresetdone_i};
      end
   end

   assign lock_s = lock_sync_q[xphy_rx_pkg::SYNC_STAGES-1];
   assign done_s = done_sync_q[xphy_rx_pkg::SYNC_STAGES-1];

   // A monitor request waits out any lock-loss reset
   assign req_start   = rxreset_req_i && !ack_q && (pulse_cnt_q == '0) && lock_s;
   assign gtrxreset_d = !lock_s || req_start ||
                        (pulse_cnt_q > xphy_rx_pkg::pulse_cnt_t'(1));

   // ----------------------------------------
   // Reset pulse and req/ack handshake
   // ----------------------------------------
   always_ff @(posedge gt0_rxusrclk2_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         pulse_cnt_q <= '0;
         ack_q       <= 1'b0;
         gtrxreset_q <= 1'b0;
      end
      else
      begin
         gtrxreset_q <= gtrxreset_d;
         if (req_start)
         begin
            pulse_cnt_q <= xphy_rx_pkg::pulse_cnt_t'(xphy_rx_pkg::RXRESET_PULSE);
         end
         else if (pulse_cnt_q != '0)
         begin
            pulse_cnt_q <= pulse_cnt_q - 1'b1;
         end

         // Ack comes as the pulse ends and stays until req is withdrawn
         if (pulse_cnt_q == xphy_rx_pkg::pulse_cnt_t'(1))
         begin
            ack_q <= 1'b1;
         end
         else if (ack_q && !rxreset_req_i)
         begin
            ack_q <= 1'b0;
         end
      end
   end

   // ----------------------------------------
   // RXUSERRDY delay after reset release
   // ----------------------------------------
   always_ff @(posedge gt0_rxusrclk2_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         wait_cnt_q  <= '0;
         rxuserrdy_q <= 1'b0;
      end
      else if (gtrxreset_d)
      begin
         wait_cnt_q  <= '0;
         rxuserrdy_q <= 1'b0;
      end
      else if (!gtrxreset_q)
      begin
         if (wait_cnt_q == xphy_rx_pkg::wait_cnt_t'(xphy_rx_pkg::RXUSERRDY_WAIT - 1))
         begin
            rxuserrdy_q <= 1'b1;
         end
         else
         begin
            wait_cnt_q <= wait_cnt_q + 1'b1;
         end
      end
   end

   // Elastic buffer reset on over or underflow once the GT is out of reset
   always_ff @(posedge gt0_rxusrclk2_i or posedge rst_i)
   begin
      if (rst_i)
      begin
         rxbufreset_q <= 1'b0;
      end
      else
      begin
         rxbufreset_q <= gt_rxbufstatus_i[xphy_rx_pkg::BUFSTATUS_ERR_BIT] && done_s;
      end
   end

   assign rxreset_ack_o  = ack_q;
   assign rx_resetdone_o = done_s;
   assign gtrxreset_o    = gtrxreset_q;
   assign rxuserrdy_o    = rxuserrdy_q;
   assign rxbufreset_o   = rxbufreset_q;

endmodule

// File: source/xphy_rx_pkg.sv
// 10GBASE-R receive housekeeping package with widths, idle patterns and timing constants
package xphy_rx_pkg;

   // ----------------------------------------
   // Datapath widths
   // ----------------------------------------
   localparam int GT_DATA_W         = 32;
   localparam int RXC_W             = 8;
   localparam int HDR_W             = 2;
   localparam int BUFSTATUS_W       = 3;
   localparam int BUFSTATUS_ERR_BIT = 2;
   localparam int NIBBLE_W          = 4;

   // Lowest bit of the watched nibble in the mapped word
   localparam int SAMPLE_LO         = 4;

   // Nibble values seen on the line when no cable is attached
   localparam logic [NIBBLE_W-1:0] IDLE_PAT_A = 4'b1010;
   localparam logic [NIBBLE_W-1:0] IDLE_PAT_B = 4'b0101;
   localparam logic [NIBBLE_W-1:0] IDLE_PAT_Z = 4'b0000;

   // ----------------------------------------
   // Watchdog and reset timing, in rxusrclk2 cycles
   // ----------------------------------------
   localparam int PULL_WINDOW    = 64;
   localparam int PULL_GOOD_RUN  = 2;
   localparam int UNPULL_WINDOW  = 256;
   localparam int UNPULL_EVENTS  = 16;
   localparam int RXRESET_PULSE  = 4;
   localparam int RXUSERRDY_WAIT = 20;
   localparam int SYNC_STAGES    = 2;

   // Counter widths derived from the timing above
   localparam int PULL_CNT_W  = $clog2(PULL_WINDOW + 1);
   localparam int RUN_CNT_W   = $clog2(PULL_GOOD_RUN + 1);
   localparam int WIN_CNT_W   = $clog2(UNPULL_WINDOW);
   localparam int EVT_CNT_W   = $clog2(UNPULL_EVENTS + 1);
   localparam int PULSE_CNT_W = $clog2(RXRESET_PULSE + 1);
   localparam int WAIT_CNT_W  = $clog2(RXUSERRDY_WAIT);

   typedef logic [PULL_CNT_W-1:0]  pull_cnt_t;
   typedef logic [RUN_CNT_W-1:0]   run_cnt_t;
   typedef logic [WIN_CNT_W-1:0]   win_cnt_t;
   typedef logic [EVT_CNT_W-1:0]   evt_cnt_t;
   typedef logic [PULSE_CNT_W-1:0] pulse_cnt_t;
   typedef logic [WAIT_CNT_W-1:0]  wait_cnt_t;

endpackage

// File: source/xphy_rx_top.sv
// 10GBASE-R receive housekeeping top joining mapping, cable monitor and reset sequencer
`timescale 1ns/1ps

module xphy_rx_top
(
   input  logic                                  gt0_rxusrclk2_i,
   input  logic                                  rst_i,
   input  logic [xphy_rx_pkg::GT_DATA_W-1:0]     gt_rxdata_i,
   input  logic [xphy_rx_pkg::HDR_W-1:0]         gt_rxheader_i,
   input  logic                                  gt_rxheadervalid_i,
   input  logic                                  gt_rxdatavalid_i,
   input  logic [xphy_rx_pkg::BUFSTATUS_W-1:0]   gt_rxbufstatus_i,
   input  logic                                  gt_rxresetdone_i,
   input  logic                                  qplllock_i,
   input  logic                                  signal_detect_i,
   output logic [xphy_rx_pkg::GT_DATA_W-1:0]     pcs_rxd_o,
   output logic [xphy_rx_pkg::RXC_W-1:0]         pcs_rxc_o,
   output logic                                  signal_detect_o,
   output logic                                  cable_pulled_o,
   output logic                                  rx_resetdone_o,
   output logic                                  gtrxreset_o,
   output logic                                  rxuserrdy_o,
   output logic                                  rxbufreset_o
);

   logic [xphy_rx_pkg::NIBBLE_W-1:0] rx_nibble;
   logic                             rxreset_req;
   logic                             rxreset_ack;
   logic                             rx_resetdone;

   rx_gearbox_map rx_gearbox_map_i
   (
      .gt0_rxusrclk2_i    (gt0_rxusrclk2_i),
      .rst_i              (rst_i),
      .gt_rxdata_i        (gt_rxdata_i),
      .gt_rxheader_i      (gt_rxheader_i),
      .gt_rxheadervalid_i (gt_rxheadervalid_i),
      .gt_rxdatavalid_i   (gt_rxdatavalid_i),
      .pcs_rxd_o          (pcs_rxd_o),
      .pcs_rxc_o          (pcs_rxc_o),
      .rx_nibble_o        (rx_nibble)
   );

   // Monitor and sequencer talk over a four-phase req/ack
   rx_cable_monitor rx_cable_monitor_i
   (
      .gt0_rxusrclk2_i (gt0_rxusrclk2_i),
      .rst_i           (rst_i),
      .rx_nibble_i     (rx_nibble),
      .rx_resetdone_i  (rx_resetdone),
      .signal_detect_i (signal_detect_i),
      .rxreset_ack_i   (rxreset_ack),
      .rxreset_req_o   (rxreset_req),
      .cable_pulled_o  (cable_pulled_o),
      .signal_detect_o (signal_detect_o)
   );

   rx_reset_sequencer rx_reset_sequencer_i
   (
      .gt0_rxusrclk2_i  (gt0_rxusrclk2_i),
      .rst_i            (rst_i),
      .qplllock_i       (qplllock_i),
      .gt_rxresetdone_i (gt_rxresetdone_i),
      .gt_rxbufstatus_i (gt_rxbufstatus_i),
      .rxreset_req_i    (rxreset_req),
      .rxreset_ack_o    (rxreset_ack),
      .rx_resetdone_o   (rx_resetdone),
      .gtrxreset_o      (gtrxreset_o),
      .rxuserrdy_o      (rxuserrdy_o),
      .rxbufreset_o     (rxbufreset_o)
   );

   assign rx_resetdone_o = rx_resetdone;

endmodule

// File: src.f
source/xphy_rx_pkg.sv
source/rx_gearbox_map.sv
source/rx_cable_monitor.sv
source/rx_reset_sequencer.sv
source/xphy_rx_top.sv
testbench/xphy_rx_assert.sv
testbench/xphy_rx_tb.sv

// File: testbench/xphy_rx_assert.sv
// Concurrent checks on the reset req/ack handshake and the GT RX reset outputs
`timescale 1ns/1ps

module xphy_rx_assert
(
   input logic gt0_rxusrclk2_i,
   input logic rst_i,
   input logic rxreset_req_i,
   input logic rxreset_ack_i,
   input logic gtrxreset_i,
   input logic rxuserrdy_i
);

   // Ack answers a pending request only
   ack_needs_req : assert property (@(posedge gt0_rxusrclk2_i) disable iff (rst_i)
      $rose(rxreset_ack_i) |-> rxreset_req_i)
      else $error("rxreset ack rose with no request pending");

   // Request is withdrawn only after the ack
   req_drop_after_ack : assert property (@(posedge gt0_rxusrclk2_i) disable iff (rst_i)
      $fell(rxreset_req_i) |-> rxreset_ack_i)
      else $error("rxreset request dropped before the ack");

   // Ack clears only once the request is gone
   ack_drop_after_req : assert property (@(posedge gt0_rxusrclk2_i) disable iff (rst_i)
      $fell(rxreset_ack_i) |-> !rxreset_req_i)
      else $error("rxreset ack dropped while the request was still high");

   rdy_not_in_reset : assert property (@(posedge gt0_rxusrclk2_i) disable iff (rst_i)
      !(rxuserrdy_i && gtrxreset_i))
      else $error("rxuserrdy high while gtrxreset is asserted");

endmodule

// File: testbench/xphy_rx_tb.sv
// Table-driven testbench for the 10GBASE-R receive housekeeping top level
`timescale 1ns/1ps

module xphy_rx_tb;

   localparam int   CLK_HALF    = 2;
   localparam int   CLK_PERIOD  = 2 * CLK_HALF;
   localparam int   RESET_CYCLES = 8;
   localparam int   ROWS        = 7;
   localparam int   MARGIN      = 200;
   localparam logic MODE_RANDOM = 1'b0;
   localparam logic MODE_IDLE   = 1'b1;

   typedef struct packed
   {
      logic        mode;
      logic [15:0] cycles;
      logic        lock;
      logic [2:0]  bufstatus;
      logic        exp_pulled;
      logic        exp_gtrxreset;
      logic        exp_rxuserrdy;
      logic        exp_sigdet;
      logic [3:0]  exp_pulses;
   } row_t;

   logic        clk;
   logic        rst_i;
   logic [31:0] gt_rxdata_i;
   logic [1:0]  gt_rxheader_i;
   logic        gt_rxheadervalid_i;
   logic        gt_rxdatavalid_i;
   logic [2:0]  gt_rxbufstatus_i;
   logic        gt_rxresetdone_i;
   logic        qplllock_i;
   logic        signal_detect_i;
   logic [31:0] pcs_rxd_o;
   logic [7:0]  pcs_rxc_o;
   logic        signal_detect_o;
   logic        cable_pulled_o;
   logic        rx_resetdone_o;
   logic        gtrxreset_o;
   logic        rxuserrdy_o;
   logic        rxbufreset_o;

   row_t        rows [ROWS];
   string       row_names [ROWS];
   string       cur_name;
   bit          table_loaded;
   int          errors;
   int          cyc;
   logic [3:0]  last_nib;

   // Previous-cycle values sampled on the falling edge
   logic [31:0] prev_data;
   logic [1:0]  prev_hdr;
   logic        prev_hv;
   logic        prev_dv;
   logic [2:0]  prev_buf;
   logic        prev_done;
   logic        prev_gtrx;
   logic        prev_rdy;
   logic        prev_pulled;
   bit          prev_valid;
   bit          rel_armed;
   bit          idle_armed;
   int          rel_cyc;
   int          idle_start;
   int          hi_run;
   int          req_pulses;
   int          lock_low;

   // Two-stage model of the reset-done synchronizer
   logic        done_d1;
   logic        done_d2;

   xphy_rx_top xphy_rx_top_i
   (
      .gt0_rxusrclk2_i    (clk),
      .rst_i              (rst_i),
      .gt_rxdata_i        (gt_rxdata_i),
      .gt_rxheader_i      (gt_rxheader_i),
      .gt_rxheadervalid_i (gt_rxheadervalid_i),
      .gt_rxdatavalid_i   (gt_rxdatavalid_i),
      .gt_rxbufstatus_i   (gt_rxbufstatus_i),
      .gt_rxresetdone_i   (gt_rxresetdone_i),
      .qplllock_i         (qplllock_i),
      .signal_detect_i    (signal_detect_i),
      .pcs_rxd_o          (pcs_rxd_o),
      .pcs_rxc_o          (pcs_rxc_o),
      .signal_detect_o    (signal_detect_o),
      .cable_pulled_o     (cable_pulled_o),
      .rx_resetdone_o     (rx_resetdone_o),
      .gtrxreset_o        (gtrxreset_o),
      .rxuserrdy_o        (rxuserrdy_o),
      .rxbufreset_o       (rxbufreset_o)
   );

   bind rx_reset_sequencer xphy_rx_assert xphy_rx_assert_i
   (
      .gt0_rxusrclk2_i (gt0_rxusrclk2_i),
      .rst_i           (rst_i),
      .rxreset_req_i   (rxreset_req_i),
      .rxreset_ack_i   (rxreset_ack_o),
      .gtrxreset_i     (gtrxreset_o),
      .rxuserrdy_i     (rxuserrdy_o)
   );

   always #(CLK_HALF) clk = ~clk;

   // ----------------------------------------
   // Helpers
   // ----------------------------------------
   function automatic logic [31:0] bit_reverse(input logic [31:0] w);
      logic [31:0] r;
      for (int i = 0; i < 32; i++)
      begin
         r[i] = w[31 - i];
      end
      return r;
   endfunction

   // A good nibble is no idle pattern and differs from the last sample
   function automatic bit nibble_is_good(input logic [3:0] nib, input logic [3:0] prev);
      return (nib != 4'b1010) && (nib != 4'b0101) && (nib != 4'b0000) && (nib != prev);
   endfunction

   task automatic report_mismatch(input string what, input logic [31:0] exp,
                                  input logic [31:0] act);
      errors++;
      $display("Mismatch in %s, %s: expected %0h, actual %0h", cur_name, what, exp, act);
   endtask

   task automatic report_failure(input string msg);
      errors++;
      $display("Error in %s: %s", cur_name, msg);
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      assert (exp === act)
      else report_mismatch(what, 32'(exp), 32'(act));
   endtask

   // One cycle of stimulus driven just after the rising edge
   task automatic drive_cycle(input logic mode, input logic lock, input logic [2:0] bufst);
      logic [31:0] mapped;
      logic [3:0]  nib;
      logic [3:0]  ctl;
      @(posedge clk);
      #0.5;
      mapped = $urandom;
      ctl    = 4'($urandom);
      if (mode == MODE_IDLE)
      begin
         nib = 4'b1010;
      end
      else
      begin
         nib = 4'($urandom);
         while (!nibble_is_good(nib, last_nib))
         begin
            nib = 4'($urandom);
         end
      end
      mapped[7:4]        = nib;
      last_nib           = nib;
      gt_rxdata_i        = bit_reverse(mapped);
      gt_rxheader_i      = ctl[1:0];
      gt_rxheadervalid_i = ctl[2];
      gt_rxdatavalid_i   = ctl[3];
      qplllock_i         = lock;
      gt_rxresetdone_i   = lock;
      gt_rxbufstatus_i   = bufst;
   endtask

   // ----------------------------------------
   // Cycle monitor
   // ----------------------------------------
   always @(negedge clk)
   begin
      cyc++;
      if (rst_i)
      begin
         prev_valid = 1'b0;
         rel_armed  = 1'b0;
         hi_run     = 0;
         lock_low   = 0;
         done_d1    = 1'b0;
         done_d2    = 1'b0;
      end
      else
      begin
         if (prev_valid)
         begin
            assert (pcs_rxd_o === bit_reverse(prev_data))
            else report_mismatch("pcs_rxd_o", bit_reverse(prev_data), pcs_rxd_o);
            assert (pcs_rxc_o === {4'b0000, prev_hv, prev_dv, prev_hdr[0], prev_hdr[1]})
            else report_mismatch("pcs_rxc_o",
                                 {28'd0, prev_hv, prev_dv, prev_hdr[0], prev_hdr[1]},
                                 32'(pcs_rxc_o));
            assert (rx_resetdone_o === done_d2)
            else report_mismatch("rx_resetdone_o", 32'(done_d2), 32'(rx_resetdone_o));
            assert (rxbufreset_o === (prev_buf[2] && prev_done))
            else report_mismatch("rxbufreset_o", 32'(prev_buf[2] && prev_done),
                                 32'(rxbufreset_o));
         end

         // Width of each gtrxreset pulse
         if (gtrxreset_o)
         begin
            hi_run++;
            rel_armed = 1'b0;
         end
         else
         begin
            if (hi_run == xphy_rx_pkg::RXRESET_PULSE)
            begin
               req_pulses++;
            end
            hi_run = 0;
         end

         if (prev_valid && prev_gtrx && !gtrxreset_o)
         begin
            rel_cyc   = cyc;
            rel_armed = 1'b1;
         end

         if (prev_valid && !prev_rdy && rxuserrdy_o)
         begin
            assert (rel_armed)
            else report_failure("rxuserrdy_o rose with no gtrxreset_o release before it");
            assert (!rel_armed || (cyc - rel_cyc == xphy_rx_pkg::RXUSERRDY_WAIT))
            else report_mismatch("rxuserrdy_o delay", xphy_rx_pkg::RXUSERRDY_WAIT,
                                 cyc - rel_cyc);
            rel_armed = 1'b0;
         end

         if (prev_valid && !prev_pulled && cable_pulled_o)
         begin
            assert (idle_armed && (cyc - idle_start <= xphy_rx_pkg::PULL_WINDOW + 8))
            else report_failure("cable_pulled_o rose late or without idle data");
            idle_armed = 1'b0;
         end

         // Lock loss must hold the GT in reset once the synchronizer has seen it
         lock_low = qplllock_i ? 0 : lock_low + 1;
         if (lock_low >= 4)
         begin
            assert (gtrxreset_o && !rxuserrdy_o)
            else report_failure("gtrxreset_o or rxuserrdy_o not held during lock loss");
         end
         prev_valid = 1'b1;
         prev_done  = done_d2;
         done_d2    = done_d1;
         done_d1    = gt_rxresetdone_i;
      end
      prev_data   = gt_rxdata_i;
      prev_hdr    = gt_rxheader_i;
      prev_hv     = gt_rxheadervalid_i;
      prev_dv     = gt_rxdatavalid_i;
      prev_buf    = gt_rxbufstatus_i;
      prev_gtrx   = gtrxreset_o;
      prev_rdy    = rxuserrdy_o;
      prev_pulled = cable_pulled_o;
   end

   // Watchdog sized from the table
   initial
   begin
      int limit;
      wait (table_loaded);
      limit = RESET_CYCLES + MARGIN;
      for (int r = 0; r < ROWS; r++)
      begin
         limit += rows[r].cycles;
      end
      #(limit * CLK_PERIOD);
      errors++;
      $display("Timeout: run did not end within %0d cycles, %0d errors", limit, errors);
      $display("*** TEST FAILED ***");
      $finish;
   end

   // ----------------------------------------
   // Main sequence
   // ----------------------------------------
   initial
   begin
      clk                = 1'b0;
      rst_i              = 1'b1;
      gt_rxdata_i        = '0;
      gt_rxheader_i      = '0;
      gt_rxheadervalid_i = 1'b0;
      gt_rxdatavalid_i   = 1'b0;
      gt_rxbufstatus_i   = '0;
      gt_rxresetdone_i   = 1'b0;
      qplllock_i         = 1'b0;
      signal_detect_i    = 1'b1;
      errors             = 0;
      cyc                = 0;
      last_nib           = '0;
      req_pulses         = 0;
      idle_armed         = 1'b0;
      cur_name           = "reset";
      void'($urandom(97));

      // Mode, cycles, lock, bufstatus, then pulled, gtrxreset, rxuserrdy, sigdet, pulses
      rows[0] = '{MODE_RANDOM, 16'd40,  1'b1, 3'b000, 1'b0, 1'b0, 1'b1, 1'b1, 4'd0};
      rows[1] = '{MODE_IDLE,   16'd120, 1'b1, 3'b000, 1'b1, 1'b0, 1'b1, 1'b0, 4'd1};
      rows[2] = '{MODE_RANDOM, 16'd300, 1'b1, 3'b000, 1'b0, 1'b0, 1'b1, 1'b1, 4'd2};
      rows[3] = '{MODE_RANDOM, 16'd10,  1'b1, 3'b100, 1'b0, 1'b0, 1'b1, 1'b1, 4'd2};
      rows[4] = '{MODE_RANDOM, 16'd10,  1'b1, 3'b000, 1'b0, 1'b0, 1'b1, 1'b1, 4'd2};
      rows[5] = '{MODE_RANDOM, 16'd30,  1'b0, 3'b000, 1'b0, 1'b1, 1'b0, 1'b1, 4'd2};
      rows[6] = '{MODE_RANDOM, 16'd40,  1'b1, 3'b000, 1'b0, 1'b0, 1'b1, 1'b1, 4'd2};
      row_names[0] = "reset_release";
      row_names[1] = "cable_pull";
      row_names[2] = "replug";
      row_names[3] = "buf_error";
      row_names[4] = "buf_clear";
      row_names[5] = "lock_loss";
      row_names[6] = "lock_return";
      table_loaded = 1'b1;

      repeat (RESET_CYCLES) drive_cycle(MODE_RANDOM, 1'b0, 3'b000);
      rst_i = 1'b0;

      for (int r = 0; r < ROWS; r++)
      begin
         cur_name = row_names[r];
         if (rows[r].mode == MODE_IDLE)
         begin
            idle_start = cyc;
            idle_armed = 1'b1;
         end
         for (int k = 0; k < rows[r].cycles; k++)
         begin
            drive_cycle(rows[r].mode, rows[r].lock, rows[r].bufstatus);
         end
         @(negedge clk);
         check_bit("cable_pulled_o", rows[r].exp_pulled, cable_pulled_o);
         check_bit("gtrxreset_o", rows[r].exp_gtrxreset, gtrxreset_o);
         check_bit("rxuserrdy_o", rows[r].exp_rxuserrdy, rxuserrdy_o);
         check_bit("signal_detect_o", rows[r].exp_sigdet, signal_detect_o);
         assert (req_pulses == rows[r].exp_pulses)
         else report_mismatch("gtrxreset request pulses", rows[r].exp_pulses, req_pulses);
      end

      $display("Run complete: %0d errors", errors);
      if (errors == 0)
      begin
         $display("*** TEST PASSED ***");
      end
      else
      begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule
